// File: vdp_top.f
+incdir+tests
rtl/vdp_pkg.sv
rtl/vdp_video_timing.sv
rtl/vdp_host_regs.sv
rtl/vdp_vram_write_port.sv
rtl/vdp_palette_output.sv
rtl/vdp_top.sv
tests/vdp_tb.sv

// File: Makefile
# Verilator simulation of the VDP testbench

VERILATOR ?= verilator
TOP       ?= vdp_tb
FILELIST  ?= vdp_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/vdp_tb_apb.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB master tasks, included inside vdp_tb
// one transfer at a time, pready may stall
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic apb_transfer(input logic write, input reg_addr_t addr,
                            input data_t wdata, output data_t rdata);
    int cycles;
    cycles = 0;
    rdata = '0;
    // setup cycle
    @(posedge clk);
    #2;
    apb_req.psel = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite = write;
    apb_req.paddr = {9'd0, addr, 1'b0};
    apb_req.pwdata = wdata;
    // access cycles until pready
    @(posedge clk);
    #2;
    apb_req.penable = 1'b1;
    @(posedge clk);
    while (!apb_rsp.pready && cycles < TIMEOUT) begin
        @(posedge clk);
        cycles++;
    end
    if (apb_rsp.pready) begin
        rdata = apb_rsp.prdata;
        apb_done_cycle = cycle_count;
        #2;
        apb_req = '0;
    end else begin
        abort_on_timeout("APB pready");
    end
endtask

task automatic apb_write(input reg_addr_t addr, input data_t wdata);
    data_t unused;
    apb_transfer(1'b1, addr, wdata, unused);
endtask

task automatic apb_read(input reg_addr_t addr, output data_t rdata);
    apb_transfer(1'b0, addr, '0, rdata);
endtask

// File: tests/vdp_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for vdp_top
// runs a few frames, every wait times out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vdp_tb import vdp_pkg::*; ();

    localparam int TIMEOUT = 600000;

    // selectors for wait_for
    localparam int SIG_LINE = 0;
    localparam int SIG_FRAME = 1;
    localparam int SIG_ACTIVE_FRAME = 2;
    localparam int SIG_HSYNC_LOW = 3;
    localparam int SIG_HSYNC_HIGH = 4;
    localparam int SIG_ANY_WE = 5;
    localparam int SIG_SHOWN = 6;
    localparam int SIG_VSYNC_LOW = 7;
    localparam int SIG_VSYNC_HIGH = 8;
    localparam int SIG_ACTIVE = 9;
    localparam int SIG_BLANK = 10;

    logic       clk;
    logic       reset;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
    logic       hsync;
    logic       vsync;
    logic       active_display;
    logic       line_ended;
    logic       frame_ended;
    logic       active_frame_ended;
    vram_addr_t even_address;
    logic       even_we;
    data_t      even_data;
    vram_addr_t odd_address;
    logic       odd_we;
    data_t      odd_data;

    int         errors = 0;
    int         timeouts = 0;
    longint     cycle_count = 0;
    longint     apb_done_cycle = 0;
    int         line_count = 0;
    int         active_frame_count = 0;
    logic [1:0] active_hist = '0;

    // words sent to VRAM and pulses seen on the ports
    data_t      sent[$];
    vram_wr_t   we_seen[$];
    longint     we_cycle[$];

    vdp_top dut_i (
        .clk                (clk),
        .reset              (reset),
        .apb_req            (apb_req),
        .apb_rsp            (apb_rsp),
        .r                  (r),
        .g                  (g),
        .b                  (b),
        .hsync              (hsync),
        .vsync              (vsync),
        .active_display     (active_display),
        .line_ended         (line_ended),
        .frame_ended        (frame_ended),
        .active_frame_ended (active_frame_ended),
        .even_address       (even_address),
        .even_we            (even_we),
        .even_data          (even_data),
        .odd_address        (odd_address),
        .odd_we             (odd_we),
        .odd_data           (odd_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        vram_wr_t seen;
        cycle_count <= cycle_count + 1;
        active_hist <= {active_hist[0], active_display};
        if (line_ended) begin
            line_count <= line_count + 1;
        end
        if (active_frame_ended) begin
            active_frame_count <= active_frame_count + 1;
        end
        if (even_we || odd_we) begin
            seen.odd = odd_we;
            seen.address = odd_we ? odd_address : even_address;
            seen.data = odd_we ? odd_data : even_data;
            we_seen.push_back(seen);
            we_cycle.push_back(cycle_count);
        end
    end

    task automatic note_failure(input string what);
        errors++;
        $display("%s", what);
    endtask

    task automatic report_mismatch(input string name, input longint expected,
                                   input longint actual);
        errors++;
        $display("ERR %s: expected %0h, actual %0h", name, expected, actual);
    endtask

    task automatic check_value(input string name, input longint expected,
                               input longint actual);
        assert (actual == expected) else report_mismatch(name, expected, actual);
    endtask

    task automatic finish_run();
        $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        timeouts++;
        $display("timed out waiting for %s", what);
        finish_run();
    endtask

    function automatic logic sig_value(input int which);
        case (which)
            SIG_LINE: return line_ended;
            SIG_FRAME: return frame_ended;
            SIG_ACTIVE_FRAME: return active_frame_ended;
            SIG_HSYNC_LOW: return !hsync;
            SIG_HSYNC_HIGH: return hsync;
            SIG_ANY_WE: return even_we || odd_we;
            SIG_SHOWN: return active_display && active_hist[0] && active_hist[1];
            SIG_VSYNC_LOW: return !vsync;
            SIG_VSYNC_HIGH: return vsync;
            SIG_ACTIVE: return active_display;
            SIG_BLANK: return !active_display;
            default: return 1'b0;
        endcase
    endfunction

    // returns at the first edge that samples the signal high
    task automatic wait_for(input int which, input string what);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!sig_value(which) && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!sig_value(which)) begin
            abort_on_timeout(what);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic check_backdrop(input string name, input color_t expected);
        wait_for(SIG_SHOWN, "active display");
        repeat (16) begin
            if (sig_value(SIG_SHOWN)) begin
                check_value(name, expected, {r, g, b});
            end
            @(posedge clk);
        end
    endtask

    task automatic check_blanking();
        wait_for(SIG_ACTIVE_FRAME, "active_frame_ended");
        // two stage colour pipeline plus the sampling edge
        wait_cycles(4);
        repeat (64) begin
            check_value("vertical blanking", 0, {r, g, b});
            @(posedge clk);
        end
    endtask

    // port, port address and word of each pulse against the host writes
    task automatic check_writes(input string name, input vram_host_addr_t first,
                                input vram_host_addr_t inc);
        vram_host_addr_t host;
        host = first;
        check_value({name, " write count"}, sent.size(), we_seen.size());
        foreach (sent[i]) begin
            if (i < we_seen.size()) begin
                check_value({name, " port"}, host[0], we_seen[i].odd);
                check_value({name, " address"}, host[14:1], we_seen[i].address);
                check_value({name, " data"}, sent[i], we_seen[i].data);
            end
            host = host + inc;
        end
    endtask

    `include "vdp_tb_apb.svh"

    assert property (@(posedge clk) disable iff (reset) !(even_we && odd_we))
        else note_failure("even and odd VRAM write enables high together");
    assert property (@(posedge clk) disable iff (reset)
                     !active_hist[1] |-> ({r, g, b} == 12'h000))
        else note_failure("RGB output not black while blanked");
    assert property (@(posedge clk) disable iff (reset) frame_ended |-> line_ended)
        else note_failure("frame_ended without line_ended");

    initial begin
        int              n;
        longint          t0;
        longint          latency;
        int              lines0;
        int              frames0;
        data_t           v;
        data_t           word_a;
        data_t           word_b;
        vram_host_addr_t base;

        void'($urandom(32'habc3e4dd));
        apb_req = '0;
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        assert (!even_we && !odd_we) else note_failure("VRAM we high after reset");

        // raster timing
        wait_for(SIG_LINE, "line_ended");
        t0 = cycle_count;
        wait_for(SIG_LINE, "line_ended");
        check_value("line period", 800, cycle_count - t0);
        wait_for(SIG_FRAME, "frame_ended");
        lines0 = line_count;
        frames0 = active_frame_count;
        wait_for(SIG_FRAME, "frame_ended");
        check_value("lines per frame", 524, line_count - lines0);
        check_value("active frame strobes", 1, active_frame_count - frames0);
        wait_for(SIG_HSYNC_HIGH, "hsync high");
        wait_for(SIG_HSYNC_LOW, "hsync low");
        t0 = cycle_count;
        wait_for(SIG_HSYNC_HIGH, "hsync high");
        check_value("hsync width", 96, cycle_count - t0);
        t0 = cycle_count;
        wait_for(SIG_ACTIVE, "active_display high");
        check_value("back porch", 48, cycle_count - t0);
        t0 = cycle_count;
        wait_for(SIG_BLANK, "active_display low");
        check_value("active width", 640, cycle_count - t0);
        wait_for(SIG_ACTIVE_FRAME, "active_frame_ended");
        t0 = cycle_count;
        wait_for(SIG_VSYNC_LOW, "vsync low");
        // from the last active pixel to the first sync line
        check_value("vsync start", 11 * 800 + 1, cycle_count - t0);
        t0 = cycle_count;
        wait_for(SIG_VSYNC_HIGH, "vsync high");
        check_value("vsync width", 2 * 800, cycle_count - t0);

        // raster readback
        wait_for(SIG_FRAME, "frame_ended");
        n = $urandom % 400;
        repeat (n) wait_for(SIG_LINE, "line_ended");
        apb_read(REG_RASTER_Y, v);
        check_value("raster y readback", n, v);
        apb_read(REG_RASTER_X, v);
        assert (v < 800) else note_failure("raster x readback beyond the line");

        // backdrop colour and blanking
        word_a = data_t'($urandom);
        apb_write(REG_PAL_ADDR, 16'd0);
        apb_write(REG_PAL_DATA, word_a);
        wait_cycles(4);
        check_backdrop("backdrop colour", word_a[11:0]);
        check_blanking();

        // pointer wraps from 255 to entry 0
        word_a = data_t'($urandom);
        word_b = data_t'($urandom);
        apb_write(REG_PAL_ADDR, 16'd255);
        apb_write(REG_PAL_DATA, word_a);
        apb_write(REG_PAL_DATA, word_b);
        wait_cycles(4);
        check_backdrop("palette wrap", word_b[11:0]);

        // port selection and address increment
        base = vram_host_addr_t'($urandom) & 15'h7ffe;
        apb_write(REG_VRAM_INC, 16'd1);
        apb_write(REG_VRAM_ADDR, data_t'(base));
        sent.delete();
        we_seen.delete();
        we_cycle.delete();
        repeat (3) begin
            sent.push_back(data_t'($urandom));
            apb_write(REG_VRAM_DATA, sent[sent.size() - 1]);
            wait_for(SIG_ANY_WE, "VRAM we");
            latency = cycle_count - apb_done_cycle;
            assert (latency >= 1 && latency <= 9)
                else note_failure("VRAM write latency outside 1 to 9 cycles");
        end
        wait_cycles(16);
        check_writes("port select", base, 15'd1);

        // second data write waits for the first pulse
        sent.delete();
        we_seen.delete();
        we_cycle.delete();
        sent.push_back(data_t'($urandom));
        sent.push_back(data_t'($urandom));
        // start of a line puts the first slot late enough to stall the second write
        wait_for(SIG_LINE, "line_ended");
        apb_write(REG_VRAM_DATA, sent[0]);
        apb_write(REG_VRAM_DATA, sent[1]);
        assert (we_cycle.size() >= 1 && apb_done_cycle >= we_cycle[0])
            else note_failure("second VRAM data write completed before the first we pulse");
        wait_for(SIG_ANY_WE, "VRAM we");
        wait_cycles(16);
        check_writes("back-pressure", base + 15'd3, 15'd1);

        finish_run();
    end

endmodule

// File: rtl/vdp_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VDP top level, APB host, VGA out, VRAM writes
// VRAM ports are write-only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vdp_top import vdp_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    input  apb_req_t   apb_req,
    output apb_rsp_t   apb_rsp,

    output logic [3:0] r,
    output logic [3:0] g,
    output logic [3:0] b,
    output logic       hsync,
    output logic       vsync,
    output logic       active_display,

    // single cycle strobes
    output logic       line_ended,
    output logic       frame_ended,
    output logic       active_frame_ended,

    output vram_addr_t even_address,
    output logic       even_we,
    output data_t      even_data,

    output vram_addr_t odd_address,
    output logic       odd_we,
    output data_t      odd_data
);

    raster_x_t raster_x;
    raster_y_t raster_y;

    logic      pal_we;
    pal_addr_t pal_addr;
    data_t     pal_data;

    vram_wr_t  vram_req;
    logic      vram_pending;
    logic      vram_grant;

    vdp_video_timing timing_i (
        .clk                (clk),
        .reset              (reset),
        .raster_x           (raster_x),
        .raster_y           (raster_y),
        .hsync              (hsync),
        .vsync              (vsync),
        .active_display     (active_display),
        .line_ended         (line_ended),
        .frame_ended        (frame_ended),
        .active_frame_ended (active_frame_ended)
    );

    vdp_host_regs regs_i (
        .clk          (clk),
        .reset        (reset),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .raster_x     (raster_x),
        .raster_y     (raster_y),
        .pal_we       (pal_we),
        .pal_addr     (pal_addr),
        .pal_data     (pal_data),
        .vram_req     (vram_req),
        .vram_pending (vram_pending),
        .vram_grant   (vram_grant)
    );

    vdp_vram_write_port vram_i (
        .clk          (clk),
        .reset        (reset),
        .raster_x     (raster_x),
        .vram_req     (vram_req),
        .vram_pending (vram_pending),
        .vram_grant   (vram_grant),
        .even_address (even_address),
        .even_we      (even_we),
        .even_data    (even_data),
        .odd_address  (odd_address),
        .odd_we       (odd_we),
        .odd_data     (odd_data)
    );

    vdp_palette_output palette_i (
        .clk            (clk),
        .pal_we         (pal_we),
        .pal_addr       (pal_addr),
        .pal_data       (pal_data),
        .active_display (active_display),
        .r              (r),
        .g              (g),
        .b              (b)
    );

endmodule

// File: rtl/vdp_palette_output.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// palette RAM and backdrop colour output
// RGB lags active_display by 2 clocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vdp_palette_output import vdp_pkg::*; (
    input  logic       clk,

    input  logic       pal_we,
    input  pal_addr_t  pal_addr,
    input  data_t      pal_data,

    input  logic       active_display,

    output logic [3:0] r,
    output logic [3:0] g,
    output logic [3:0] b
);

    data_t  pal_ram [256];
    color_t backdrop;
    logic   active_q;
    color_t rgb_q;

    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_ram[pal_addr] <= pal_data;
        end
        // entry 0 is the backdrop
        backdrop <= pal_ram[0][11:0];
        active_q <= active_display;
    end

    // blank to black outside the active window
    always_ff @(posedge clk) begin
        rgb_q <= active_q ? backdrop : '0;
    end

    assign r = rgb_q[11:8];
    assign g = rgb_q[7:4];
    assign b = rgb_q[3:0];

endmodule

// File: rtl/vdp_vram_write_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host write slot sequencer for split VRAM
// one write slot every 8 clocks
// addresses hold their value between writes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vdp_vram_write_port import vdp_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    input  raster_x_t  raster_x,

    input  vram_wr_t   vram_req,
    input  logic       vram_pending,
    output logic       vram_grant,

    output vram_addr_t even_address,
    output logic       even_we,
    output data_t      even_data,

    output vram_addr_t odd_address,
    output logic       odd_we,
    output data_t      odd_data
);

    // slot position follows the low raster bits
    assign vram_grant = vram_pending && (raster_x[2:0] == VRAM_SLOT);

    always_ff @(posedge clk) begin
        if (reset) begin
            even_we <= 1'b0;
            odd_we <= 1'b0;
        end else begin
            even_we <= vram_grant && !vram_req.odd;
            odd_we <= vram_grant && vram_req.odd;
        end
    end

    // both ports see the same word, only one gets we
    always_ff @(posedge clk) begin
        if (vram_grant) begin
            even_address <= vram_req.address;
            even_data <= vram_req.data;
            odd_address <= vram_req.address;
            odd_data <= vram_req.data;
        end
    end

endmodule

// File: rtl/vdp_host_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB register block of the VDP
// only one VRAM write can be pending, a second
// VRAM data write is stalled with pready low
// writes to unmapped registers are dropped
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vdp_host_regs import vdp_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    input  apb_req_t  apb_req,
    output apb_rsp_t  apb_rsp,

    input  raster_x_t raster_x,
    input  raster_y_t raster_y,

    output logic      pal_we,
    output pal_addr_t pal_addr,
    output data_t     pal_data,

    output vram_wr_t  vram_req,
    output logic      vram_pending,
    input  logic      vram_grant
);

    reg_addr_t       reg_addr;
    logic            access;
    logic            wr_stall;
    logic            wr_fire;

    vram_host_addr_t vram_addr;
    vram_host_addr_t vram_inc;
    data_t           vram_data;

    assign reg_addr = apb_req.paddr[6:1];
    assign access = apb_req.psel && apb_req.penable;

    // previous word not yet placed in its slot
    assign wr_stall = access && apb_req.pwrite && (reg_addr == REG_VRAM_DATA) && vram_pending;
    assign wr_fire = access && apb_req.pwrite && !wr_stall;

    always_comb begin
        apb_rsp.pready = !wr_stall;
        apb_rsp.prdata = '0;
        if (access && !apb_req.pwrite) begin
            case (reg_addr)
                REG_RASTER_X: apb_rsp.prdata = data_t'(raster_x);
                REG_RASTER_Y: apb_rsp.prdata = data_t'(raster_y);
                default: apb_rsp.prdata = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pal_we <= 1'b0;
            pal_addr <= '0;
            vram_pending <= 1'b0;
            vram_addr <= '0;
            vram_inc <= '0;
        end else begin
            pal_we <= wr_fire && (reg_addr == REG_PAL_DATA);

            // pointer steps after each palette write
            if (pal_we) begin
                pal_addr <= pal_addr + 1'b1;
            end

            if (vram_grant) begin
                vram_pending <= 1'b0;
                vram_addr <= vram_addr + vram_inc;
            end

            // a host write overrides the automatic updates above
            if (wr_fire) begin
                case (reg_addr)
                    REG_PAL_ADDR: pal_addr <= apb_req.pwdata[7:0];
                    REG_VRAM_ADDR: vram_addr <= apb_req.pwdata[14:0];
                    REG_VRAM_DATA: vram_pending <= 1'b1;
                    REG_VRAM_INC: vram_inc <= apb_req.pwdata[14:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire && reg_addr == REG_PAL_DATA) begin
            pal_data <= apb_req.pwdata;
        end
        if (wr_fire && reg_addr == REG_VRAM_DATA) begin
            vram_data <= apb_req.pwdata;
        end
    end

    always_comb begin
        vram_req.address = vram_addr[14:1];
        vram_req.data = vram_data;
        vram_req.odd = vram_addr[0];
    end

endmodule

// File: rtl/vdp_video_timing.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 640x480 raster generator, all outputs registered
// sync pulses are active low
// strobes are single cycle, not for VGA pins
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vdp_video_timing import vdp_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    output raster_x_t raster_x,
    output raster_y_t raster_y,

    output logic      hsync,
    output logic      vsync,
    output logic      active_display,

    output logic      line_ended,
    output logic      frame_ended,
    output logic      active_frame_ended
);

    raster_x_t x_next;
    raster_y_t y_next;
    logic      x_wrap;

    // outputs are decoded from the next position so they line up with the counters
    always_comb begin
        x_wrap = (raster_x == raster_x_t'(H_TOTAL - 1));
        x_next = x_wrap ? '0 : raster_x + 1'b1;
        y_next = raster_y;
        if (x_wrap) begin
            y_next = (raster_y == raster_y_t'(V_TOTAL - 1)) ? '0 : raster_y + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            raster_x <= '0;
            raster_y <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
            active_display <= 1'b0;
            line_ended <= 1'b0;
            frame_ended <= 1'b0;
            active_frame_ended <= 1'b0;
        end else begin
            raster_x <= x_next;
            raster_y <= y_next;

            // sync windows sit right after the front porches
            hsync <= !(x_next >= raster_x_t'(H_FRONTPORCH) &&
                       x_next < raster_x_t'(H_FRONTPORCH + H_SYNC));
            vsync <= !(y_next >= raster_y_t'(V_ACTIVE + V_FRONTPORCH) &&
                       y_next < raster_y_t'(V_ACTIVE + V_FRONTPORCH + V_SYNC));

            active_display <= (x_next >= raster_x_t'(H_OFFSCREEN)) &&
                              (y_next < raster_y_t'(V_ACTIVE));

            line_ended <= (x_next == raster_x_t'(H_TOTAL - 1));
            frame_ended <= (x_next == raster_x_t'(H_TOTAL - 1)) &&
                           (y_next == raster_y_t'(V_TOTAL - 1));
            active_frame_ended <= (x_next == raster_x_t'(H_TOTAL - 1)) &&
                                  (y_next == raster_y_t'(V_ACTIVE - 1));
        end
    end

endmodule

// File: rtl/vdp_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared constants and types of the VDP
// timing is fixed at 640x480, no widescreen
// VRAM is write-only, split even/odd ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package vdp_pkg;

    // horizontal timing, offscreen region comes first in the line
    localparam int H_ACTIVE = 640;
    localparam int H_FRONTPORCH = 16;
    localparam int H_SYNC = 96;
    localparam int H_BACKPORCH = 48;
    localparam int H_OFFSCREEN = H_FRONTPORCH + H_SYNC + H_BACKPORCH;

    // vertical timing, active lines come first in the frame
    localparam int V_ACTIVE = 480;
    localparam int V_FRONTPORCH = 11;
    localparam int V_SYNC = 2;
    localparam int V_BACKPORCH = 31;

    localparam int H_TOTAL = H_ACTIVE + H_OFFSCREEN;
    localparam int V_TOTAL = V_ACTIVE + V_FRONTPORCH + V_SYNC + V_BACKPORCH;

    typedef logic [11:0] raster_x_t;
    typedef logic [10:0] raster_y_t;

    // register word address, APB byte address bits 6:1
    typedef logic [5:0] reg_addr_t;

    // write map
    localparam reg_addr_t REG_PAL_ADDR = 6'd2;
    localparam reg_addr_t REG_PAL_DATA = 6'd3;
    localparam reg_addr_t REG_VRAM_ADDR = 6'd4;
    localparam reg_addr_t REG_VRAM_DATA = 6'd5;
    localparam reg_addr_t REG_VRAM_INC = 6'd6;

    // read map
    localparam reg_addr_t REG_RASTER_X = 6'd0;
    localparam reg_addr_t REG_RASTER_Y = 6'd2;

    typedef logic [15:0] data_t;
    typedef logic [13:0] vram_addr_t;

    // bit 0 picks the port, bits 14:1 are the port word address
    typedef logic [14:0] vram_host_addr_t;

    typedef logic [7:0] pal_addr_t;

    // RGB444, low 12 bits of a palette word
    typedef logic [11:0] color_t;

    // raster_x[2:0] value of the host write slot
    localparam logic [2:0] VRAM_SLOT = 3'd0;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [15:0] paddr;
        data_t       pwdata;
    } apb_req_t;

    typedef struct packed {
        data_t prdata;
        logic  pready;
    } apb_rsp_t;

    // one pending host word write
    typedef struct packed {
        vram_addr_t address;
        data_t      data;
        logic       odd;
    } vram_wr_t;

endpackage
